//--- common/l15_adapter_pkg.sv
// shared definitions for the L1.5 adapter
// widths, queue depths, L1.5 packet encodings and cache-side return types
// modules pull these in with a wildcard import in their header

package l15_adapter_pkg;

  ////////////////////////////////////////////////////////////
  // widths and data types
  ////////////////////////////////////////////////////////////

  localparam int PADDR_W = 40;

  typedef logic [PADDR_W-1:0] paddr_t;
  typedef logic [63:0]        word_t;
  // instruction fill line, two words
  typedef logic [127:0]       line_t;
  // transaction id rides in the L1.5 thread id field
  typedef logic [1:0]         tid_t;
  typedef logic [2:0]         size_t;
  // invalidation address bits 15..4 from the L1.5
  typedef logic [11:0]        inv_addr_t;
  typedef logic [15:0]        inv_idx_t;

  // queue depths
  localparam int REQ_FIFO_DEPTH  = 2;
  localparam int RTRN_FIFO_DEPTH = 2;

  // size codes for instruction misses
  localparam size_t SIZE_WORD = 3'b010;
  localparam size_t SIZE_LINE = 3'b111;

  ////////////////////////////////////////////////////////////
  // encodings
  ////////////////////////////////////////////////////////////

  typedef enum logic {
    DCACHE_LOAD_REQ  = 1'b0,
    DCACHE_STORE_REQ = 1'b1
  } dcache_rtype_e;

  // L1.5 request types
  typedef enum logic [4:0] {
    L15_LOAD_RQ  = 5'b00000,
    L15_STORE_RQ = 5'b00001,
    L15_IMISS_RQ = 5'b10000
  } l15_rqtype_e;

  // L1.5 return types, others are ignored by the decoder
  typedef enum logic [3:0] {
    L15_LOAD_RET  = 4'b0000,
    L15_IFILL_RET = 4'b0001,
    L15_EVICT_REQ = 4'b0011,
    L15_ST_ACK    = 4'b0100
  } l15_rtntype_e;

  typedef enum logic {
    ICACHE_IFILL_ACK,
    ICACHE_INV_REQ
  } icache_rtype_e;

  typedef enum logic [1:0] {
    DCACHE_LOAD_ACK,
    DCACHE_STORE_ACK,
    DCACHE_INV_REQ
  } dcache_rrtype_e;

  // packed queue words: {paddr, nc, tid}
  localparam int ICACHE_REQ_W = PADDR_W + 1 + $bits(tid_t);
  // {type, paddr, nc, size, tid, data}
  localparam int DCACHE_REQ_W = 1 + PADDR_W + 1 + $bits(size_t) + $bits(tid_t) + $bits(word_t);
  // {type, tid, nc, data1, data0, inv_addr, inv_icache, inv_dcache}
  localparam int RTRN_W = $bits(l15_rtntype_e) + $bits(tid_t) + 1 + 2 * $bits(word_t) +
                          $bits(inv_addr_t) + 2;

  // byte reversal between little-endian caches and big-endian L1.5
  function automatic word_t swap64(input word_t d);
    word_t r;
    for (int i = 0; i < 8; i++) begin
      r[8*i +: 8] = d[8*(7-i) +: 8];
    end
    return r;
  endfunction

endpackage

//--- verilog/sync_fifo.sv
// first-word-fall-through queue, circular buffer with a fill count
// head is on data_o one cycle after the push that wrote it
// push while full and pop while empty are dropped

`timescale 1ns/1ps

module sync_fifo #(
  parameter int WIDTH = 8,
  parameter int DEPTH = 2
) (
  input  logic             clk_i,
  input  logic             rst_n_i,
  input  logic             push_i,
  input  logic [WIDTH-1:0] data_i,
  output logic             full_o,
  input  logic             pop_i,
  output logic [WIDTH-1:0] data_o,
  output logic             empty_o
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  logic [WIDTH-1:0] mem [DEPTH];
  logic [PTR_W-1:0] wptr_q;
  logic [PTR_W-1:0] rptr_q;
  logic [CNT_W-1:0] cnt_q;
  logic             push_ok;
  logic             pop_ok;

  assign full_o  = (cnt_q == CNT_W'(DEPTH));
  assign empty_o = (cnt_q == '0);
  assign push_ok = push_i & ~full_o;
  assign pop_ok  = pop_i & ~empty_o;
  // head of queue
  assign data_o  = mem[rptr_q];

  // storage, payload only
  always_ff @(posedge clk_i) begin
    if (push_ok) begin
      mem[wptr_q] <= data_i;
    end
  end

  // pointers wrap at DEPTH-1, depth need not be a power of two
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wptr_q <= '0;
      rptr_q <= '0;
      cnt_q  <= '0;
    end else begin
      if (push_ok) begin
        wptr_q <= (wptr_q == PTR_W'(DEPTH - 1)) ? '0 : wptr_q + 1'b1;
      end
      if (pop_ok) begin
        rptr_q <= (rptr_q == PTR_W'(DEPTH - 1)) ? '0 : rptr_q + 1'b1;
      end
      // simultaneous push and pop leaves the count alone
      if (push_ok && !pop_ok) begin
        cnt_q <= cnt_q + 1'b1;
      end else if (pop_ok && !push_ok) begin
        cnt_q <= cnt_q - 1'b1;
      end
    end
  end

endmodule

//--- request/l15_req_arbiter.sv
// round-robin arbiter with lock-in between the instruction and data queues
// builds the L1.5 request packet from the granted queue head
// store data is byte-reversed for the big-endian L1.5

`timescale 1ns/1ps

module l15_req_arbiter import l15_adapter_pkg::*; (
  input  logic          clk_i,
  input  logic          rst_n_i,
  // instruction queue head
  input  logic          icache_vld_i,
  input  paddr_t        icache_paddr_i,
  input  logic          icache_nc_i,
  input  tid_t          icache_tid_i,
  // data queue head
  input  logic          dcache_vld_i,
  input  dcache_rtype_e dcache_type_i,
  input  paddr_t        dcache_paddr_i,
  input  logic          dcache_nc_i,
  input  size_t         dcache_size_i,
  input  tid_t          dcache_tid_i,
  input  word_t         dcache_data_i,
  input  logic          l15_ack_i,
  // queue pops
  output logic          icache_pop_o,
  output logic          dcache_pop_o,
  // L1.5 request
  output logic          l15_val_o,
  output l15_rqtype_e   l15_rqtype_o,
  output logic          l15_nc_o,
  output size_t         l15_size_o,
  output tid_t          l15_tid_o,
  output paddr_t        l15_addr_o,
  output word_t         l15_data_o
);

  // side served last, 0 icache and 1 dcache
  logic last_q;
  // a request is pending without ack, grant is frozen
  logic lock_q;
  logic lock_idx_q;
  logic idx;
  logic done;

  ////////////////////////////////////////////////////////////
  // arbitration
  ////////////////////////////////////////////////////////////

  always_comb begin
    if (lock_q) begin
      idx = lock_idx_q;
    end else if (icache_vld_i && dcache_vld_i) begin
      idx = ~last_q;
    end else begin
      idx = dcache_vld_i;
    end
  end

  assign l15_val_o = icache_vld_i | dcache_vld_i;
  assign done      = l15_val_o & l15_ack_i;

  // pointer only moves on ack
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      last_q     <= 1'b1;
      lock_q     <= 1'b0;
      lock_idx_q <= 1'b0;
    end else if (done) begin
      last_q <= idx;
      lock_q <= 1'b0;
    end else if (l15_val_o) begin
      lock_q     <= 1'b1;
      lock_idx_q <= idx;
    end
  end

  // ack pops the granted queue
  assign icache_pop_o = done & ~idx;
  assign dcache_pop_o = done & idx;

  ////////////////////////////////////////////////////////////
  // packet encoding
  ////////////////////////////////////////////////////////////

  always_comb begin
    l15_rqtype_o = L15_IMISS_RQ;
    if (idx) begin
      l15_rqtype_o = (dcache_type_i == DCACHE_STORE_REQ) ? L15_STORE_RQ : L15_LOAD_RQ;
    end
  end

  // non-cacheable fetches are single words, the rest full lines
  assign l15_size_o = idx ? dcache_size_i : (icache_nc_i ? SIZE_WORD : SIZE_LINE);
  assign l15_nc_o   = idx ? dcache_nc_i : icache_nc_i;
  assign l15_tid_o  = idx ? dcache_tid_i : icache_tid_i;
  assign l15_addr_o = idx ? dcache_paddr_i : icache_paddr_i;
  // no payload on instruction misses
  assign l15_data_o = idx ? swap64(dcache_data_i) : '0;

endmodule

//--- return/l15_rtrn_decoder.sv
// return path from the L1.5
// queues accepted packets, pops the head every cycle and routes it
// to the instruction or data cache, which must take it at once
// data is byte-reversed back to little-endian

`timescale 1ns/1ps

module l15_rtrn_decoder import l15_adapter_pkg::*; (
  input  logic           clk_i,
  input  logic           rst_n_i,
  // L1.5 return
  input  logic           l15_rtrn_val_i,
  output logic           l15_rtrn_ready_o,
  input  l15_rtntype_e   l15_rtrn_type_i,
  input  tid_t           l15_rtrn_tid_i,
  input  logic           l15_rtrn_nc_i,
  input  word_t          l15_rtrn_data0_i,
  input  word_t          l15_rtrn_data1_i,
  input  inv_addr_t      l15_rtrn_inv_addr_i,
  input  logic           l15_rtrn_inv_icache_i,
  input  logic           l15_rtrn_inv_dcache_i,
  // instruction cache return
  output logic           icache_rtrn_valid_o,
  output icache_rtype_e  icache_rtrn_type_o,
  output tid_t           icache_rtrn_tid_o,
  output logic           icache_rtrn_nc_o,
  output line_t          icache_rtrn_data_o,
  output inv_idx_t       icache_rtrn_inv_idx_o,
  // data cache return
  output logic           dcache_rtrn_valid_o,
  output dcache_rrtype_e dcache_rtrn_type_o,
  output tid_t           dcache_rtrn_tid_o,
  output word_t          dcache_rtrn_data_o,
  output inv_idx_t       dcache_rtrn_inv_idx_o
);

  logic [RTRN_W-1:0] rtrn_word;
  logic [RTRN_W-1:0] rtrn_head;
  logic              rtrn_full;
  logic              rtrn_empty;
  // unpacked head fields
  logic [3:0]        head_type_raw;
  l15_rtntype_e      head_type;
  tid_t              head_tid;
  logic              head_nc;
  word_t             head_data0;
  word_t             head_data1;
  inv_addr_t         head_inv_addr;
  logic              head_inv_ic;
  logic              head_inv_dc;

  assign l15_rtrn_ready_o = ~rtrn_full;
  assign rtrn_word = {l15_rtrn_type_i, l15_rtrn_tid_i, l15_rtrn_nc_i, l15_rtrn_data1_i,
                      l15_rtrn_data0_i, l15_rtrn_inv_addr_i, l15_rtrn_inv_icache_i,
                      l15_rtrn_inv_dcache_i};

  // popped every non-empty cycle, so each packet is seen exactly once
  sync_fifo #(
    .WIDTH   (RTRN_W),
    .DEPTH   (RTRN_FIFO_DEPTH)
  ) i_rtrn_fifo (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .push_i  (l15_rtrn_val_i & l15_rtrn_ready_o),
    .data_i  (rtrn_word),
    .full_o  (rtrn_full),
    .pop_i   (~rtrn_empty),
    .data_o  (rtrn_head),
    .empty_o (rtrn_empty)
  );

  assign {head_type_raw, head_tid, head_nc, head_data1, head_data0, head_inv_addr,
          head_inv_ic, head_inv_dc} = rtrn_head;
  assign head_type = l15_rtntype_e'(head_type_raw);

  ////////////////////////////////////////////////////////////
  // type decode
  ////////////////////////////////////////////////////////////

  always_comb begin
    icache_rtrn_valid_o = 1'b0;
    dcache_rtrn_valid_o = 1'b0;
    icache_rtrn_type_o  = ICACHE_IFILL_ACK;
    dcache_rtrn_type_o  = DCACHE_LOAD_ACK;
    if (!rtrn_empty) begin
      case (head_type)
        L15_LOAD_RET: begin
          dcache_rtrn_valid_o = 1'b1;
        end
        L15_ST_ACK: begin
          dcache_rtrn_type_o  = DCACHE_STORE_ACK;
          dcache_rtrn_valid_o = 1'b1;
        end
        L15_IFILL_RET: begin
          icache_rtrn_valid_o = 1'b1;
        end
        // invalidation goes to each flagged side, possibly both
        L15_EVICT_REQ: begin
          icache_rtrn_type_o  = ICACHE_INV_REQ;
          dcache_rtrn_type_o  = DCACHE_INV_REQ;
          icache_rtrn_valid_o = head_inv_ic;
          dcache_rtrn_valid_o = head_inv_dc;
        end
        default: begin
          // unsupported return, dropped
        end
      endcase
    end
  end

  // line layout: swapped data1 above swapped data0
  assign icache_rtrn_data_o    = {swap64(head_data1), swap64(head_data0)};
  assign dcache_rtrn_data_o    = swap64(head_data0);
  assign icache_rtrn_tid_o     = head_tid;
  assign dcache_rtrn_tid_o     = head_tid;
  assign icache_rtrn_nc_o      = head_nc;
  // index is the 16 bit line address
  assign icache_rtrn_inv_idx_o = {head_inv_addr, 4'b0000};
  assign dcache_rtrn_inv_idx_o = {head_inv_addr, 4'b0000};

endmodule

//--- verilog/l15_adapter_top.sv
// adapter between the L1 instruction and data caches and the L1.5 port
// each cache request side has its own small queue, the arbiter merges
// them into one L1.5 request, the decoder routes returns back

`timescale 1ns/1ps

module l15_adapter_top import l15_adapter_pkg::*; (
  input  logic           clk_i,
  input  logic           rst_n_i,
  // instruction cache requests
  input  logic           icache_req_valid_i,
  output logic           icache_req_ready_o,
  input  paddr_t         icache_req_paddr_i,
  input  logic           icache_req_nc_i,
  input  tid_t           icache_req_tid_i,
  // data cache requests
  input  logic           dcache_req_valid_i,
  output logic           dcache_req_ready_o,
  input  dcache_rtype_e  dcache_req_type_i,
  input  paddr_t         dcache_req_paddr_i,
  input  logic           dcache_req_nc_i,
  input  size_t          dcache_req_size_i,
  input  tid_t           dcache_req_tid_i,
  input  word_t          dcache_req_data_i,
  // L1.5 request
  output logic           l15_val_o,
  input  logic           l15_ack_i,
  output l15_rqtype_e    l15_rqtype_o,
  output logic           l15_nc_o,
  output size_t          l15_size_o,
  output tid_t           l15_tid_o,
  output paddr_t         l15_addr_o,
  output word_t          l15_data_o,
  // L1.5 return
  input  logic           l15_rtrn_val_i,
  output logic           l15_rtrn_ready_o,
  input  l15_rtntype_e   l15_rtrn_type_i,
  input  tid_t           l15_rtrn_tid_i,
  input  logic           l15_rtrn_nc_i,
  input  word_t          l15_rtrn_data0_i,
  input  word_t          l15_rtrn_data1_i,
  input  inv_addr_t      l15_rtrn_inv_addr_i,
  input  logic           l15_rtrn_inv_icache_i,
  input  logic           l15_rtrn_inv_dcache_i,
  // returns to the caches, valid only
  output logic           icache_rtrn_valid_o,
  output icache_rtype_e  icache_rtrn_type_o,
  output tid_t           icache_rtrn_tid_o,
  output logic           icache_rtrn_nc_o,
  output line_t          icache_rtrn_data_o,
  output inv_idx_t       icache_rtrn_inv_idx_o,
  output logic           dcache_rtrn_valid_o,
  output dcache_rrtype_e dcache_rtrn_type_o,
  output tid_t           dcache_rtrn_tid_o,
  output word_t          dcache_rtrn_data_o,
  output inv_idx_t       dcache_rtrn_inv_idx_o
);

  logic [ICACHE_REQ_W-1:0] ic_head;
  logic [DCACHE_REQ_W-1:0] dc_head;
  logic                    ic_full;
  logic                    ic_empty;
  logic                    ic_pop;
  logic                    dc_full;
  logic                    dc_empty;
  logic                    dc_pop;
  // unpacked queue heads
  paddr_t                  ic_paddr;
  logic                    ic_nc;
  tid_t                    ic_tid;
  logic                    dc_type;
  paddr_t                  dc_paddr;
  logic                    dc_nc;
  size_t                   dc_size;
  tid_t                    dc_tid;
  word_t                   dc_data;

  ////////////////////////////////////////////////////////////
  // request queues
  ////////////////////////////////////////////////////////////

  assign icache_req_ready_o = ~ic_full;
  assign dcache_req_ready_o = ~dc_full;

  sync_fifo #(
    .WIDTH   (ICACHE_REQ_W),
    .DEPTH   (REQ_FIFO_DEPTH)
  ) i_icache_fifo (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .push_i  (icache_req_valid_i & icache_req_ready_o),
    .data_i  ({icache_req_paddr_i, icache_req_nc_i, icache_req_tid_i}),
    .full_o  (ic_full),
    .pop_i   (ic_pop),
    .data_o  (ic_head),
    .empty_o (ic_empty)
  );

  sync_fifo #(
    .WIDTH   (DCACHE_REQ_W),
    .DEPTH   (REQ_FIFO_DEPTH)
  ) i_dcache_fifo (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .push_i  (dcache_req_valid_i & dcache_req_ready_o),
    .data_i  ({dcache_req_type_i, dcache_req_paddr_i, dcache_req_nc_i, dcache_req_size_i,
               dcache_req_tid_i, dcache_req_data_i}),
    .full_o  (dc_full),
    .pop_i   (dc_pop),
    .data_o  (dc_head),
    .empty_o (dc_empty)
  );

  assign {ic_paddr, ic_nc, ic_tid} = ic_head;
  assign {dc_type, dc_paddr, dc_nc, dc_size, dc_tid, dc_data} = dc_head;

  ////////////////////////////////////////////////////////////
  // arbiter and return decoder
  ////////////////////////////////////////////////////////////

  l15_req_arbiter i_arbiter (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .icache_vld_i   (~ic_empty),
    .icache_paddr_i (ic_paddr),
    .icache_nc_i    (ic_nc),
    .icache_tid_i   (ic_tid),
    .dcache_vld_i   (~dc_empty),
    .dcache_type_i  (dcache_rtype_e'(dc_type)),
    .dcache_paddr_i (dc_paddr),
    .dcache_nc_i    (dc_nc),
    .dcache_size_i  (dc_size),
    .dcache_tid_i   (dc_tid),
    .dcache_data_i  (dc_data),
    .l15_ack_i      (l15_ack_i),
    .icache_pop_o   (ic_pop),
    .dcache_pop_o   (dc_pop),
    .l15_val_o      (l15_val_o),
    .l15_rqtype_o   (l15_rqtype_o),
    .l15_nc_o       (l15_nc_o),
    .l15_size_o     (l15_size_o),
    .l15_tid_o      (l15_tid_o),
    .l15_addr_o     (l15_addr_o),
    .l15_data_o     (l15_data_o)
  );

  l15_rtrn_decoder i_rtrn_decoder (
    .clk_i                 (clk_i),
    .rst_n_i               (rst_n_i),
    .l15_rtrn_val_i        (l15_rtrn_val_i),
    .l15_rtrn_ready_o      (l15_rtrn_ready_o),
    .l15_rtrn_type_i       (l15_rtrn_type_i),
    .l15_rtrn_tid_i        (l15_rtrn_tid_i),
    .l15_rtrn_nc_i         (l15_rtrn_nc_i),
    .l15_rtrn_data0_i      (l15_rtrn_data0_i),
    .l15_rtrn_data1_i      (l15_rtrn_data1_i),
    .l15_rtrn_inv_addr_i   (l15_rtrn_inv_addr_i),
    .l15_rtrn_inv_icache_i (l15_rtrn_inv_icache_i),
    .l15_rtrn_inv_dcache_i (l15_rtrn_inv_dcache_i),
    .icache_rtrn_valid_o   (icache_rtrn_valid_o),
    .icache_rtrn_type_o    (icache_rtrn_type_o),
    .icache_rtrn_tid_o     (icache_rtrn_tid_o),
    .icache_rtrn_nc_o      (icache_rtrn_nc_o),
    .icache_rtrn_data_o    (icache_rtrn_data_o),
    .icache_rtrn_inv_idx_o (icache_rtrn_inv_idx_o),
    .dcache_rtrn_valid_o   (dcache_rtrn_valid_o),
    .dcache_rtrn_type_o    (dcache_rtrn_type_o),
    .dcache_rtrn_tid_o     (dcache_rtrn_tid_o),
    .dcache_rtrn_data_o    (dcache_rtrn_data_o),
    .dcache_rtrn_inv_idx_o (dcache_rtrn_inv_idx_o)
  );

endmodule

//--- test/l15_adapter_props.sv
// concurrent checks on the adapter top level, attached with bind
// lock-in of the L1.5 request, reset state and return routing

`timescale 1ns/1ps

module l15_adapter_props import l15_adapter_pkg::*; (
  input logic           clk_i,
  input logic           rst_n_i,
  input logic           l15_val_o,
  input logic           l15_ack_i,
  input l15_rqtype_e    l15_rqtype_o,
  input logic           l15_nc_o,
  input paddr_t         l15_addr_o,
  input word_t          l15_data_o,
  input size_t          l15_size_o,
  input tid_t           l15_tid_o,
  input logic           icache_rtrn_valid_o,
  input logic           dcache_rtrn_valid_o,
  input icache_rtype_e  icache_rtrn_type_o,
  input dcache_rrtype_e dcache_rtrn_type_o
);

  // pending request holds still until acked
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    l15_val_o && !l15_ack_i |=> l15_val_o && $stable(l15_rqtype_o) && $stable(l15_addr_o) &&
      $stable(l15_data_o) && $stable(l15_size_o) && $stable(l15_tid_o) && $stable(l15_nc_o))
    else $error("L1.5 request changed before ack");

  assert property (@(posedge clk_i) $rose(rst_n_i) |-> !l15_val_o)
    else $error("l15_val_o high right after reset");

  // only an invalidation reaches both caches at once
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    icache_rtrn_valid_o && dcache_rtrn_valid_o |->
      icache_rtrn_type_o == ICACHE_INV_REQ && dcache_rtrn_type_o == DCACHE_INV_REQ)
    else $error("non-invalidation return on both sides");

endmodule

bind l15_adapter_top l15_adapter_props i_props (
  .clk_i               (clk_i),
  .rst_n_i             (rst_n_i),
  .l15_val_o           (l15_val_o),
  .l15_ack_i           (l15_ack_i),
  .l15_rqtype_o        (l15_rqtype_o),
  .l15_nc_o            (l15_nc_o),
  .l15_addr_o          (l15_addr_o),
  .l15_data_o          (l15_data_o),
  .l15_size_o          (l15_size_o),
  .l15_tid_o           (l15_tid_o),
  .icache_rtrn_valid_o (icache_rtrn_valid_o),
  .dcache_rtrn_valid_o (dcache_rtrn_valid_o),
  .icache_rtrn_type_o  (icache_rtrn_type_o),
  .dcache_rtrn_type_o  (dcache_rtrn_type_o)
);

//--- test/l15_adapter_tb.sv
// testbench for the L1.5 adapter top level
// requests and returns come from the testdata file, an L1.5 model acks
// requests at random and per-side scoreboards check the encoded packets
// returns are sent after the request traffic has drained

`timescale 1ns/1ps

module l15_adapter_tb import l15_adapter_pkg::*; ();

  localparam int MAX_N = 32;

  logic clk_i;
  logic rst_n_i;
  logic icache_req_valid_i, icache_req_ready_o, icache_req_nc_i;
  paddr_t icache_req_paddr_i;
  tid_t icache_req_tid_i;
  logic dcache_req_valid_i, dcache_req_ready_o, dcache_req_nc_i;
  dcache_rtype_e dcache_req_type_i;
  paddr_t dcache_req_paddr_i;
  size_t dcache_req_size_i;
  tid_t dcache_req_tid_i;
  word_t dcache_req_data_i;
  logic l15_val_o, l15_ack_i, l15_nc_o;
  l15_rqtype_e l15_rqtype_o;
  size_t l15_size_o;
  tid_t l15_tid_o;
  paddr_t l15_addr_o;
  word_t l15_data_o;
  logic l15_rtrn_val_i, l15_rtrn_ready_o, l15_rtrn_nc_i;
  l15_rtntype_e l15_rtrn_type_i;
  tid_t l15_rtrn_tid_i;
  word_t l15_rtrn_data0_i, l15_rtrn_data1_i;
  inv_addr_t l15_rtrn_inv_addr_i;
  logic l15_rtrn_inv_icache_i, l15_rtrn_inv_dcache_i;
  logic icache_rtrn_valid_o, icache_rtrn_nc_o, dcache_rtrn_valid_o;
  icache_rtype_e icache_rtrn_type_o;
  dcache_rrtype_e dcache_rtrn_type_o;
  tid_t icache_rtrn_tid_o, dcache_rtrn_tid_o;
  line_t icache_rtrn_data_o;
  word_t dcache_rtrn_data_o;
  inv_idx_t icache_rtrn_inv_idx_o, dcache_rtrn_inv_idx_o;

  // vectors from the data file
  logic [39:0] ic_addr [MAX_N];
  logic        ic_nc [MAX_N];
  logic [1:0]  ic_tid [MAX_N];
  logic [39:0] dc_addr [MAX_N];
  logic [7:0]  dc_ctl [MAX_N];
  logic [63:0] dc_data [MAX_N];
  logic [3:0]  rt_type [MAX_N];
  logic [1:0]  rt_tid [MAX_N];
  logic        rt_nc [MAX_N];
  logic [63:0] rt_d0 [MAX_N];
  logic [63:0] rt_d1 [MAX_N];
  logic [11:0] rt_inv_addr [MAX_N];
  // {inv_ic, inv_dc}
  logic [1:0]  rt_inv [MAX_N];
  // {exp_ic, exp_dc}
  logic [1:0]  rt_exp [MAX_N];
  logic [15:0] rt_idx [MAX_N];
  int ic_n, dc_n, rt_n, n_lines;
  int ic_chk_n, dc_chk_n;
  int seed;
  logic loaded;

  l15_adapter_top uut (.*);

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  task automatic report_failure(input string line);
    $display("%s", line);
    $display("TEST FAIL");
    $fatal(1, "stopping on first failure");
  endtask

  // big-endian view of a little-endian word
  function automatic logic [63:0] byte_reverse(input logic [63:0] d);
    return {d[7:0], d[15:8], d[23:16], d[31:24], d[39:32], d[47:40], d[55:48], d[63:56]};
  endfunction

  ////////////////////////////////////////////////////////////
  // data file
  ////////////////////////////////////////////////////////////

  task automatic load_vectors();
    int fd;
    string line;
    byte kind;
    logic [63:0] a, b, c, d, e, f, g, h, k, m, n;
    fd = $fopen("test/l15_adapter_testdata.txt", "r");
    if (fd == 0) report_failure("could not open the test data file");
    while (!$feof(fd)) begin
      line = "";
      void'($fgets(line, fd));
      if (line.len() < 2 || line[0] == "#") continue;
      n_lines++;
      void'($sscanf(line, "%c", kind));
      if (kind == "I") begin
        void'($sscanf(line, "%c %h %h %h", kind, a, b, c));
        ic_addr[ic_n] = a[39:0];
        ic_nc[ic_n]   = b[0];
        ic_tid[ic_n]  = c[1:0];
        ic_n++;
      end else if (kind == "D") begin
        void'($sscanf(line, "%c %h %h %h %h %h %h", kind, a, b, c, d, e, f));
        dc_addr[dc_n] = b[39:0];
        // {type, nc, size, tid}
        dc_ctl[dc_n]  = {1'b0, a[0], c[0], d[2:0], e[1:0]};
        dc_data[dc_n] = f;
        dc_n++;
      end else begin
        void'($sscanf(line, "%c %h %h %h %h %h %h %h %h %h %h %h",
                      kind, a, b, c, d, e, f, g, h, k, m, n));
        rt_type[rt_n]     = a[3:0];
        rt_tid[rt_n]      = b[1:0];
        rt_nc[rt_n]       = c[0];
        rt_d0[rt_n]       = d;
        rt_d1[rt_n]       = e;
        rt_inv_addr[rt_n] = f[11:0];
        rt_inv[rt_n]      = {g[0], h[0]};
        rt_exp[rt_n]      = {k[0], m[0]};
        rt_idx[rt_n]      = n[15:0];
        rt_n++;
      end
    end
    $fclose(fd);
  endtask

  ////////////////////////////////////////////////////////////
  // request drivers and L1.5 model
  ////////////////////////////////////////////////////////////

  task automatic drive_icache();
    @(negedge clk_i);
    for (int i = 0; i < ic_n; i++) begin
      icache_req_valid_i = 1'b1;
      icache_req_paddr_i = ic_addr[i];
      icache_req_nc_i    = ic_nc[i];
      icache_req_tid_i   = ic_tid[i];
      // ready only moves on a clock edge
      while (!icache_req_ready_o) @(negedge clk_i);
      @(negedge clk_i);
      if (i % 3 == 2) begin
        icache_req_valid_i = 1'b0;
        repeat (2) @(negedge clk_i);
      end
    end
    icache_req_valid_i = 1'b0;
  endtask

  task automatic drive_dcache();
    @(negedge clk_i);
    for (int i = 0; i < dc_n; i++) begin
      dcache_req_valid_i = 1'b1;
      dcache_req_type_i  = dcache_rtype_e'(dc_ctl[i][6]);
      dcache_req_paddr_i = dc_addr[i];
      dcache_req_nc_i    = dc_ctl[i][5];
      dcache_req_size_i  = dc_ctl[i][4:2];
      dcache_req_tid_i   = dc_ctl[i][1:0];
      dcache_req_data_i  = dc_data[i];
      while (!dcache_req_ready_o) @(negedge clk_i);
      @(negedge clk_i);
      if (i % 4 == 3) begin
        dcache_req_valid_i = 1'b0;
        @(negedge clk_i);
      end
    end
    dcache_req_valid_i = 1'b0;
  endtask

  // compare a completing request with the next entry of its side
  task automatic check_request();
    int j;
    if (l15_rqtype_o == L15_IMISS_RQ) begin
      j = ic_chk_n;
      assert (j < ic_n) else report_failure($sformatf("error at %0t: extra imiss", $time));
      assert (l15_addr_o == ic_addr[j] && l15_nc_o == ic_nc[j] &&
              l15_tid_o == ic_tid[j] && l15_data_o == 64'h0 &&
              l15_size_o == (ic_nc[j] ? 3'b010 : 3'b111))
        else report_failure($sformatf("error at %0t: imiss %0d addr %h size %b tid %0d",
                                      $time, j, l15_addr_o, l15_size_o, l15_tid_o));
      ic_chk_n++;
    end else begin
      j = dc_chk_n;
      assert (j < dc_n) else report_failure($sformatf("error at %0t: extra data req", $time));
      assert (l15_rqtype_o == (dc_ctl[j][6] ? L15_STORE_RQ : L15_LOAD_RQ) &&
              l15_addr_o == dc_addr[j] && l15_size_o == dc_ctl[j][4:2] &&
              l15_nc_o == dc_ctl[j][5] &&
              l15_tid_o == dc_ctl[j][1:0] && l15_data_o == byte_reverse(dc_data[j]))
        else report_failure($sformatf("error at %0t: data req %0d type %b addr %h data %h",
                                      $time, j, l15_rqtype_o, l15_addr_o, l15_data_o));
      dc_chk_n++;
    end
  endtask

  // ack about 60 percent of cycles, check what completes at the next edge
  task automatic run_l15_model();
    forever begin
      @(negedge clk_i);
      l15_ack_i = ({$random(seed)} % 10) < 6;
      #2;
      if (l15_val_o && l15_ack_i) check_request();
    end
  endtask

  ////////////////////////////////////////////////////////////
  // returns
  ////////////////////////////////////////////////////////////

  task automatic send_return(input int i);
    logic [3:0] t;
    logic exp_ic, exp_dc;
    t      = rt_type[i];
    exp_ic = rt_exp[i][1];
    exp_dc = rt_exp[i][0];
    @(negedge clk_i);
    l15_rtrn_val_i        = 1'b1;
    l15_rtrn_type_i       = l15_rtntype_e'(t);
    l15_rtrn_tid_i        = rt_tid[i];
    l15_rtrn_nc_i         = rt_nc[i];
    l15_rtrn_data0_i      = rt_d0[i];
    l15_rtrn_data1_i      = rt_d1[i];
    l15_rtrn_inv_addr_i   = rt_inv_addr[i];
    l15_rtrn_inv_icache_i = rt_inv[i][1];
    l15_rtrn_inv_dcache_i = rt_inv[i][0];
    assert (l15_rtrn_ready_o) else report_failure("return queue refused a packet");
    @(negedge clk_i);
    l15_rtrn_val_i = 1'b0;
    #2;
    assert (icache_rtrn_valid_o == exp_ic && dcache_rtrn_valid_o == exp_dc)
      else report_failure($sformatf("error at %0t: return %0d valids ic %b dc %b",
                                    $time, i, icache_rtrn_valid_o, dcache_rtrn_valid_o));
    if (exp_ic) begin
      assert (icache_rtrn_type_o == ((t == 4'b0001) ? ICACHE_IFILL_ACK : ICACHE_INV_REQ) &&
              icache_rtrn_tid_o == rt_tid[i] && icache_rtrn_nc_o == rt_nc[i] &&
              (t != 4'b0001 || icache_rtrn_data_o ==
                 {byte_reverse(rt_d1[i]), byte_reverse(rt_d0[i])}) &&
              (t != 4'b0011 || icache_rtrn_inv_idx_o == rt_idx[i]))
        else report_failure($sformatf("error at %0t: icache return %0d type %b data %h",
                                      $time, i, icache_rtrn_type_o, icache_rtrn_data_o));
    end
    if (exp_dc) begin
      assert (dcache_rtrn_type_o == ((t == 4'b0000) ? DCACHE_LOAD_ACK :
                                     (t == 4'b0100) ? DCACHE_STORE_ACK : DCACHE_INV_REQ) &&
              dcache_rtrn_tid_o == rt_tid[i] &&
              (t == 4'b0011 || dcache_rtrn_data_o == byte_reverse(rt_d0[i])) &&
              (t != 4'b0011 || dcache_rtrn_inv_idx_o == rt_idx[i]))
        else report_failure($sformatf("error at %0t: dcache return %0d type %b data %h",
                                      $time, i, dcache_rtrn_type_o, dcache_rtrn_data_o));
    end
    // each packet is seen for one cycle only
    @(negedge clk_i);
    #2;
    assert (!icache_rtrn_valid_o && !dcache_rtrn_valid_o)
      else report_failure($sformatf("error at %0t: return %0d still valid a cycle later",
                                    $time, i));
  endtask

  // watchdog
  initial begin
    wait (loaded === 1'b1);
    #((200 + 40 * n_lines) * 8);
    report_failure("timeout: the test did not finish in the expected time");
  end

  initial begin
    seed = 74;
    loaded = 1'b0;
    rst_n_i = 1'b0;
    {icache_req_valid_i, icache_req_nc_i, icache_req_paddr_i, icache_req_tid_i} = '0;
    {dcache_req_valid_i, dcache_req_nc_i, dcache_req_paddr_i} = '0;
    {dcache_req_size_i, dcache_req_tid_i, dcache_req_data_i} = '0;
    dcache_req_type_i = DCACHE_LOAD_REQ;
    l15_ack_i = 1'b0;
    {l15_rtrn_val_i, l15_rtrn_nc_i, l15_rtrn_tid_i, l15_rtrn_data0_i} = '0;
    {l15_rtrn_data1_i, l15_rtrn_inv_addr_i, l15_rtrn_inv_icache_i} = '0;
    l15_rtrn_inv_dcache_i = 1'b0;
    l15_rtrn_type_i = L15_LOAD_RET;
    {ic_n, dc_n, rt_n, n_lines, ic_chk_n, dc_chk_n} = '0;
    load_vectors();
    loaded = 1'b1;
    repeat (3) @(posedge clk_i);
    @(negedge clk_i);
    // reset state: nothing valid, every ready high
    assert (!l15_val_o && !icache_rtrn_valid_o && !dcache_rtrn_valid_o &&
            icache_req_ready_o && dcache_req_ready_o && l15_rtrn_ready_o)
      else report_failure($sformatf("error at %0t: wrong outputs in reset", $time));
    rst_n_i = 1'b1;
    fork
      run_l15_model();
    join_none
    fork
      drive_icache();
      drive_dcache();
    join
    // scoreboards must drain exactly
    wait (ic_chk_n == ic_n && dc_chk_n == dc_n);
    repeat (3) @(negedge clk_i);
    assert (!l15_val_o) else report_failure("requests left over after the scoreboards drained");
    for (int i = 0; i < rt_n; i++) begin
      send_return(i);
    end
    $display("TEST PASS");
    $finish;
  end

endmodule

//--- test/l15_adapter_testdata.txt
# I paddr nc tid | D type paddr nc size tid data (all hex)
# R type tid nc data0 data1 inv_addr inv_ic inv_dc exp_ic exp_dc exp_idx
I 0000001000 0 0
I 0000001040 1 1
I 00000010c0 0 2
I 8000002000 1 3
I 0000003000 0 1
I 0000003040 0 2
D 0 0000400008 0 3 1 0000000000000000
D 1 0000400010 0 3 2 0123456789abcdef
D 1 0000400018 1 2 3 00000000deadbeef
D 0 0000400020 0 1 0 0000000000000000
D 1 0000400028 0 0 1 00000000000000a5
D 0 0000400030 1 3 2 0000000000000000
D 1 0000400038 0 3 3 fedcba9876543210
R 1 2 0 0011223344556677 8899aabbccddeeff 000 0 0 1 0 0000
R 0 1 0 0102030405060708 0000000000000000 000 0 0 0 1 0000
R 4 3 0 0000000000000000 0000000000000000 000 0 0 0 1 0000
R 3 0 0 0000000000000000 0000000000000000 abc 1 0 1 0 abc0
R 3 1 0 0000000000000000 0000000000000000 123 0 1 0 1 1230
R 3 2 0 0000000000000000 0000000000000000 fff 1 1 1 1 fff0
R 7 0 0 0000000000000000 0000000000000000 000 0 0 0 0 0000
R 1 3 1 a1a2a3a4a5a6a7a8 b1b2b3b4b5b6b7b8 000 0 0 1 0 0000

//--- flist.f
common/l15_adapter_pkg.sv
verilog/sync_fifo.sv
request/l15_req_arbiter.sv
return/l15_rtrn_decoder.sv
verilog/l15_adapter_top.sv
test/l15_adapter_props.sv
test/l15_adapter_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= l15_adapter_tb
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f flist.f --top-module $(TOP) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "TEST PASS" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
